//--- hw/uartPkg.sv
package uartPkg;

    // clocks per serial bit
    typedef logic [11:0] comRateT;

    localparam int DATA_BITS = 8;  // data bits per character

    localparam logic LINE_IDLE = 1'b1;  // idle and stop level

endpackage

//--- hw/configPkg.sv
package configPkg;

    typedef logic [7:0] byteT;
    typedef logic [31:0] wordT;
    typedef logic [3:0] nibbleT;

    // header sequence that opens every frame
    localparam byteT HEADER_0 = 8'h00;
    localparam byteT HEADER_1 = 8'hAA;
    localparam byteT HEADER_2 = 8'hFF;

    // accepted codes in the low 7 bits of the command byte
    localparam logic [6:0] CMD_LOAD_A = 7'd1;
    localparam logic [6:0] CMD_LOAD_B = 7'd2;

    localparam int HEX_MODE_BIT = 7;  // set means ASCII-hex payload

    typedef enum logic [2:0] {
        IDLE,
        GET_H0,
        GET_H1,
        GET_H2,
        GET_COMMAND,
        EVAL_COMMAND,
        GET_DATA
    } frameStateT;

    typedef logic [15:0] timeoutT;

endpackage

//--- hw/uartByteReceiver.sv
`timescale 1ns/1ps
module uartByteReceiver #(
    parameter uartPkg::comRateT ComRate = 12'd217
) (
    input logic CLK,
    input logic resetn,
    input logic Rx,
    output configPkg::byteT rxByte,
    output logic byteValid,
    output logic startSeen
);

    import uartPkg::*;

    typedef enum logic [1:0] {
        RX_WAIT,
        RX_START,
        RX_DATA,
        RX_STOP
    } rxStateT;

    rxStateT rxState;
    logic rxSync;
    comRateT comCount;
    logic comTick;
    logic [$clog2(DATA_BITS)-1:0] bitCount;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxSync <= LINE_IDLE;
        end else begin
            rxSync <= Rx;
        end
    end

    // half a bit after the start edge, then one tick per bit
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            comCount <= '0;
            comTick <= 1'b0;
        end else if (rxState == RX_WAIT) begin
            comCount <= ComRate >> 1;
            comTick <= 1'b0;
        end else if (comCount == '0) begin
            comCount <= ComRate;
            comTick <= 1'b1;
        end else begin
            comCount <= comCount - 1'b1;
            comTick <= 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxState <= RX_WAIT;
            bitCount <= '0;
        end else begin
            case (rxState)
                RX_WAIT: begin
                    if (rxSync != LINE_IDLE) begin
                        rxState <= RX_START;
                    end
                end
                RX_START: begin
                    bitCount <= '0;
                    if (comTick) begin
                        rxState <= RX_DATA;  // middle of the start bit
                    end
                end
                RX_DATA: begin
                    if (comTick) begin
                        if (bitCount == DATA_BITS - 1) begin
                            rxState <= RX_STOP;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (comTick) begin
                        rxState <= RX_WAIT;
                    end
                end
                default: begin
                    rxState <= RX_WAIT;
                end
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge CLK) begin
        if (rxState == RX_DATA && comTick) begin
            rxByte <= {rxSync, rxByte[DATA_BITS-1:1]};
        end
    end

    assign byteValid = (rxState == RX_STOP) && comTick;  // stop bit sampled
    assign startSeen = (rxState == RX_WAIT) && (rxSync != LINE_IDLE);

endmodule

//--- hw/frameController.sv
`timescale 1ns/1ps
module frameController #(
    parameter configPkg::timeoutT TimeoutCycles = 16'd16776
) (
    input logic CLK,
    input logic resetn,
    input configPkg::byteT rxByte,
    input logic byteValid,
    input logic startSeen,
    output configPkg::byteT command,
    output logic dataActive,
    output logic frameAccept,
    output logic hexMode
);

    import configPkg::*;

    frameStateT state;
    byteT header0;
    byteT header1;
    byteT header2;
    timeoutT timeoutCount;
    logic timedOut;
    logic headerOk;
    logic commandOk;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            timeoutCount <= TimeoutCycles;
        end else if (state == IDLE || byteValid) begin
            timeoutCount <= TimeoutCycles;  // restart on every byte
        end else if (timeoutCount != '0) begin
            timeoutCount <= timeoutCount - 1'b1;
        end
    end

    assign timedOut = (timeoutCount == '0);

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state <= IDLE;
            command <= '0;
        end else if (state != IDLE && timedOut) begin
            state <= IDLE;  // line went quiet
        end else begin
            case (state)
                IDLE: begin
                    if (startSeen) begin
                        state <= GET_H0;
                    end
                end
                GET_H0: begin
                    if (byteValid) begin
                        state <= GET_H1;
                    end
                end
                GET_H1: begin
                    if (byteValid) begin
                        state <= GET_H2;
                    end
                end
                GET_H2: begin
                    if (byteValid) begin
                        state <= GET_COMMAND;
                    end
                end
                GET_COMMAND: begin
                    if (byteValid) begin
                        command <= rxByte;
                        state <= EVAL_COMMAND;
                    end
                end
                EVAL_COMMAND: begin
                    if (headerOk && commandOk) begin
                        state <= GET_DATA;
                    end else begin
                        state <= IDLE;
                    end
                end
                GET_DATA: begin
                    state <= GET_DATA;  // left only through the timeout
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (byteValid) begin
            case (state)
                GET_H0: header0 <= rxByte;
                GET_H1: header1 <= rxByte;
                GET_H2: header2 <= rxByte;
                default: begin
                end
            endcase
        end
    end

    assign headerOk = (header0 == HEADER_0) && (header1 == HEADER_1) && (header2 == HEADER_2);
    assign commandOk = (command[6:0] == CMD_LOAD_A) || (command[6:0] == CMD_LOAD_B);

    assign frameAccept = (state == EVAL_COMMAND) && headerOk && commandOk;
    assign dataActive = (state == GET_DATA);
    assign hexMode = command[HEX_MODE_BIT];

endmodule

//--- hw/hexPairDecoder.sv
`timescale 1ns/1ps
module hexPairDecoder (
    input logic CLK,
    input logic resetn,
    input configPkg::byteT rxByte,
    input logic byteValid,
    input logic dataActive,
    output configPkg::byteT hexByte,
    output logic hexValid
);

    import configPkg::*;

    nibbleT highNibble;
    logic lowPhase;  // high nibble already held
    logic charOk;
    nibbleT charNibble;

    // anything outside 0-9, A-F and a-f is flagged
    always_comb begin
        charOk = 1'b1;
        charNibble = '0;
        if (rxByte >= 8'h30 && rxByte <= 8'h39) begin
            charNibble = nibbleT'(rxByte - 8'h30);
        end else if (rxByte >= 8'h41 && rxByte <= 8'h46) begin
            charNibble = nibbleT'(rxByte - 8'h37);
        end else if (rxByte >= 8'h61 && rxByte <= 8'h66) begin
            charNibble = nibbleT'(rxByte - 8'h57);
        end else begin
            charOk = 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            lowPhase <= 1'b0;
            hexValid <= 1'b0;
        end else begin
            hexValid <= dataActive && byteValid && charOk && lowPhase;
            if (!dataActive) begin
                lowPhase <= 1'b0;
            end else if (byteValid) begin
                lowPhase <= charOk && !lowPhase;  // bad char restarts the pair
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (byteValid && charOk) begin
            if (lowPhase) begin
                hexByte <= {highNibble, charNibble};
            end else begin
                highNibble <= charNibble;
            end
        end
    end

endmodule

//--- hw/wordAssembler.sv
`timescale 1ns/1ps
module wordAssembler (
    input logic CLK,
    input logic resetn,
    input configPkg::byteT rxByte,
    input logic byteValid,
    input configPkg::byteT hexByte,
    input logic hexValid,
    input logic hexMode,
    input logic dataActive,
    input logic frameAccept,
    output configPkg::wordT WriteData,
    output logic WriteStrobe
);

    import configPkg::*;

    byteT selByte;
    logic selStrobe;
    byteT byteQ;
    logic byteStrobeQ;
    logic [1:0] bytePos;  // 0 is the most significant byte

    assign selByte = hexMode ? hexByte : rxByte;
    assign selStrobe = hexMode ? hexValid : (byteValid && dataActive);

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            byteStrobeQ <= 1'b0;
        end else begin
            byteStrobeQ <= selStrobe;
        end
    end

    always_ff @(posedge CLK) begin
        if (selStrobe) begin
            byteQ <= selByte;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            WriteData <= '0;
            WriteStrobe <= 1'b0;
            bytePos <= '0;
        end else begin
            WriteStrobe <= byteStrobeQ && (bytePos == 2'd3);
            if (frameAccept) begin
                WriteData <= '0;  // new frame starts at the top byte
                bytePos <= '0;
            end else if (byteStrobeQ) begin
                WriteData[{~bytePos, 3'b000} +: 8] <= byteQ;  // ~pos equals 3 - pos
                bytePos <= bytePos + 1'b1;
            end
        end
    end

endmodule

//--- hw/configUartTop.sv
`timescale 1ns/1ps
module configUartTop #(
    parameter uartPkg::comRateT ComRate = 12'd217,  // f_CLK / baud rate
    parameter configPkg::timeoutT TimeoutCycles = 16'd16776
) (
    input logic CLK,
    input logic resetn,
    input logic Rx,
    output configPkg::wordT WriteData,
    output logic WriteStrobe,
    output configPkg::byteT Command,
    output logic ComActive
);

    import configPkg::*;

    byteT rxByte;
    logic byteValid;
    logic startSeen;
    logic dataActive;
    logic frameAccept;
    logic hexMode;
    byteT hexByte;
    logic hexValid;

    uartByteReceiver #(
        .ComRate(ComRate)
    ) receiver_i (
        .CLK(CLK),
        .resetn(resetn),
        .Rx(Rx),
        .rxByte(rxByte),
        .byteValid(byteValid),
        .startSeen(startSeen)
    );

    frameController #(
        .TimeoutCycles(TimeoutCycles)
    ) controller_i (
        .CLK(CLK),
        .resetn(resetn),
        .rxByte(rxByte),
        .byteValid(byteValid),
        .startSeen(startSeen),
        .command(Command),
        .dataActive(dataActive),
        .frameAccept(frameAccept),
        .hexMode(hexMode)
    );

    hexPairDecoder decoder_i (
        .CLK(CLK),
        .resetn(resetn),
        .rxByte(rxByte),
        .byteValid(byteValid),
        .dataActive(dataActive),
        .hexByte(hexByte),
        .hexValid(hexValid)
    );

    wordAssembler assembler_i (
        .CLK(CLK),
        .resetn(resetn),
        .rxByte(rxByte),
        .byteValid(byteValid),
        .hexByte(hexByte),
        .hexValid(hexValid),
        .hexMode(hexMode),
        .dataActive(dataActive),
        .frameAccept(frameAccept),
        .WriteData(WriteData),
        .WriteStrobe(WriteStrobe)
    );

    assign ComActive = dataActive;  // payload phase of a frame

endmodule

//--- verification/uartDriver.svh
// holds one line level for a full bit period
task automatic driveBit(input logic level);
    @(posedge CLK);
    #1;
    Rx = level;
    repeat (BitClocks - 1) @(posedge CLK);
endtask

task automatic sendChar(input byteT value);
    int i;
    driveBit(1'b0);  // start bit
    for (i = 0; i < 8; i++) begin
        driveBit(value[i]);  // lsb first
    end
    driveBit(1'b1);  // stop bit
    repeat (randomBelow(4)) @(posedge CLK);  // uneven idle gap
endtask

task automatic sendFrameStart(input byteT h0, input byteT h1, input byteT h2, input byteT cmd);
    sendChar(h0);
    sendChar(h1);
    sendChar(h2);
    sendChar(cmd);
endtask

// ascii '0' is 0x30, 'A' is 0x41, 'a' is 0x61
function automatic byteT hexChar(input nibbleT value, input logic upper);
    if (value < 4'd10) begin
        return 8'h30 + byteT'(value);
    end else if (upper) begin
        return 8'h41 + byteT'(value - 4'd10);
    end
    return 8'h61 + byteT'(value - 4'd10);
endfunction

function automatic logic isHexChar(input byteT c);
    return (c >= 8'h30 && c <= 8'h39) || (c >= 8'h41 && c <= 8'h46)
        || (c >= 8'h61 && c <= 8'h66);
endfunction

function automatic byteT randomNonHex();
    byteT c;
    c = byteT'($random(seed));
    while (isHexChar(c)) begin
        c = byteT'($random(seed));
    end
    return c;
endfunction

// high nibble first
task automatic sendHexByte(input byteT value, input logic upper);
    sendChar(hexChar(value[7:4], upper));
    sendChar(hexChar(value[3:0], upper));
endtask

//--- verification/configUartTb.sv
`timescale 1ns/1ps
module configUartTb;

    import uartPkg::*;
    import configPkg::*;

    localparam comRateT ComRate = 12'd8;
    localparam timeoutT TimeoutCycles = 16'd400;
    localparam int BitClocks = int'(ComRate) + 1;  // receiver ticks every ComRate+1 clocks
    localparam int MaxWords = 4;
    localparam int MaxFrameChars = 4 + (MaxWords * 4 + 3) * 3;  // two hex chars plus a stray
    localparam int Rounds = 4;
    localparam int FramesPerRound = 6;
    localparam int IdleClocks = int'(TimeoutCycles) + 4 * BitClocks;
    localparam int CycleLimit = Rounds * FramesPerRound
        * (MaxFrameChars * BitClocks * 11 + IdleClocks) + 1000;

    logic CLK;
    logic resetn;
    logic Rx;
    wordT WriteData;
    logic WriteStrobe;
    byteT Command;
    logic ComActive;

    int seed;
    int cycleCount = 0;
    logic mustStayInactive;  // set while a frame has to be rejected
    wordT expectedWords[$];

    configUartTop #(
        .ComRate(ComRate),
        .TimeoutCycles(TimeoutCycles)
    ) dut_i (
        .CLK(CLK),
        .resetn(resetn),
        .Rx(Rx),
        .WriteData(WriteData),
        .WriteStrobe(WriteStrobe),
        .Command(Command),
        .ComActive(ComActive)
    );

    function automatic int randomBelow(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    `include "uartDriver.svh"

    task automatic reportError(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compareWord(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            reportError($sformatf("Fail at %0t ns: %s expected 0x%h, got 0x%h",
                $time, name, expected, actual));
        end
    endtask

    task automatic compareByte(input string name, input byteT actual, input byteT expected);
        if (actual !== expected) begin
            reportError($sformatf("Fail at %0t ns: %s expected 0x%h, got 0x%h",
                $time, name, expected, actual));
        end
    endtask

    // line quiet for longer than the inactivity limit
    task automatic waitForTimeout();
        repeat (IdleClocks) @(negedge CLK);
        if (ComActive !== 1'b0) begin
            reportError("ComActive still high after the inactivity timeout");
        end
    endtask

    task automatic sendAcceptedFrame(input logic hex, input int byteCount);
        byteT cmd;
        byteT payload[$];
        int i;
        cmd = {hex, (randomBelow(2) == 0) ? 7'd1 : 7'd2};
        for (i = 0; i < byteCount; i++) begin
            payload.push_back(byteT'($random(seed)));
        end
        for (i = 0; i + 3 < byteCount; i += 4) begin
            expectedWords.push_back({payload[i], payload[i+1], payload[i+2], payload[i+3]});
        end
        sendFrameStart(8'h00, 8'hAA, 8'hFF, cmd);
        while (ComActive !== 1'b1) @(negedge CLK);
        compareByte("Command", Command, cmd);
        for (i = 0; i < byteCount; i++) begin
            if (!hex) begin
                sendChar(payload[i]);
            end else begin
                if (randomBelow(4) == 0) begin
                    sendChar(randomNonHex());  // stray char before a high nibble
                end
                sendHexByte(payload[i], randomBelow(2) == 1);
            end
        end
        while (expectedWords.size() != 0) @(negedge CLK);
        waitForTimeout();  // leftover bytes of a partial word stay unwritten
    endtask

    task automatic sendRejectedFrame(input logic badHeader);
        byteT hdr[3];
        logic [6:0] code;
        int i;
        hdr[0] = 8'h00;
        hdr[1] = 8'hAA;
        hdr[2] = 8'hFF;
        code = (randomBelow(2) == 0) ? 7'd1 : 7'd2;
        if (badHeader) begin
            i = randomBelow(3);
            hdr[i] = hdr[i] ^ (byteT'(randomBelow(255)) + 8'd1);  // never a zero flip
        end else begin
            while (code == 7'd1 || code == 7'd2) begin
                code = 7'($random(seed));
            end
        end
        mustStayInactive = 1'b1;
        sendFrameStart(hdr[0], hdr[1], hdr[2], {randomBelow(2) == 1, code});
        for (i = randomBelow(4); i > 0; i--) begin
            sendChar(byteT'($random(seed)));  // fewer than four bytes never reach a command
        end
        waitForTimeout();
        mustStayInactive = 1'b0;
    endtask

    task automatic sendPartialHeader();
        byteT hdr[3];
        int count;
        int i;
        hdr[0] = 8'h00;
        hdr[1] = 8'hAA;
        hdr[2] = 8'hFF;
        count = 1 + randomBelow(3);
        mustStayInactive = 1'b1;
        for (i = 0; i < count; i++) begin
            sendChar(hdr[i]);
        end
        waitForTimeout();
        mustStayInactive = 1'b0;
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            reportError($sformatf("Run did not finish within %0d clock cycles", CycleLimit));
        end
    end

    // outputs sampled mid-cycle
    always @(negedge CLK) begin
        if (resetn) begin
            if (WriteStrobe === 1'b1) begin
                if (expectedWords.size() == 0) begin
                    reportError("WriteStrobe pulsed while no word was expected");
                end else begin
                    compareWord("WriteData", WriteData, expectedWords.pop_front());
                end
            end
            if (mustStayInactive && ComActive !== 1'b0) begin
                reportError("ComActive went high for a frame that must be rejected");
            end
        end
    end

    initial begin
        int round;
        seed = 32'hd357_1d1f;
        mustStayInactive = 1'b0;
        resetn = 1'b0;
        Rx = 1'b1;  // idle line
        repeat (5) @(posedge CLK);
        #1;
        resetn = 1'b1;
        @(negedge CLK);
        compareWord("WriteData", WriteData, 32'h0);
        compareByte("Command", Command, 8'h00);
        if (WriteStrobe !== 1'b0 || ComActive !== 1'b0) begin
            reportError("WriteStrobe or ComActive not low after reset");
        end
        for (round = 0; round < Rounds; round++) begin
            sendAcceptedFrame(1'b0, 4 * (1 + randomBelow(MaxWords)));
            sendAcceptedFrame(1'b1, 4 * (1 + randomBelow(MaxWords)));
            sendRejectedFrame(1'b1);
            sendRejectedFrame(1'b0);
            sendPartialHeader();
            sendAcceptedFrame(randomBelow(2) == 1,
                4 * randomBelow(MaxWords) + 1 + randomBelow(3));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- all.f
+incdir+verification
hw/uartPkg.sv
hw/configPkg.sv
hw/uartByteReceiver.sv
hw/frameController.sv
hw/hexPairDecoder.sv
hw/wordAssembler.sv
hw/configUartTop.sv
verification/configUartTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module configUartTb -o configUartSim \
    && ./obj_dir/configUartSim | tee /dev/stderr | grep -F -q "TESTBENCH PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
